//--- Bender.yml
package:
  name: riscv_em

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/riscv_em_pkg.sv
      - rtl/riscv_ex_unit.sv
      - rtl/riscv_ppreg_em.sv
      - rtl/riscv_mem_stage.sv
      - rtl/riscv_em_ctrl.sv
      - rtl/riscv_em_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - bench/riscv_em_assertions.sv
      - bench/riscv_em_tb.sv

//--- bench/riscv_em_assertions.sv
`timescale 1ns/1ns

module riscv_em_assertions (
    input logic                     i_riscv_em_clk,
    input logic                     i_riscv_em_rst,
    input logic                     i_issue_ready,
    input logic                     i_retire_valid,
    input riscv_em_pkg::em_retire_t i_retire,
    input logic                     i_retire_ready,
    input logic                     i_em_flush,
    input riscv_em_pkg::em_exmem_t  i_em_q
);

    int fails = 0;

    a_reset_valid: assert property (@(posedge i_riscv_em_clk)
        i_riscv_em_rst || $fell(i_riscv_em_rst) |-> !i_retire_valid)
    else
    begin
        fails++;
        $error("retire valid high in or right after reset");
    end

    // payload frozen while the consumer stalls.
    a_retire_stable: assert property (@(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_retire_valid && !i_retire_ready |=> i_retire_valid && $stable(i_retire))
    else
    begin
        fails++;
        $error("retire record changed under back-pressure");
    end

    a_trap_blocks_issue: assert property (@(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_retire_valid && i_retire.trap != riscv_em_pkg::TRAP_NONE |-> !i_issue_ready)
    else
    begin
        fails++;
        $error("issue ready while a trap waits to retire");
    end

    a_flush_clears: assert property (@(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_em_flush |=> !i_em_q.valid && !i_issue_ready)
    else
    begin
        fails++;
        $error("EM entry or issue ready survived a flush");
    end

endmodule

bind riscv_em_top riscv_em_assertions u_sva (
    .i_riscv_em_clk (i_riscv_em_clk),
    .i_riscv_em_rst (i_riscv_em_rst),
    .i_issue_ready  (o_issue_ready),
    .i_retire_valid (o_retire_valid),
    .i_retire       (o_retire),
    .i_retire_ready (i_retire_ready),
    .i_em_flush     (em_flush),
    .i_em_q         (em_q)
);

//--- bench/riscv_em_tb.sv
`timescale 1ns/1ns
`include "riscv_em_cfg.svh"

module riscv_em_tb;

    logic                      i_riscv_em_clk;
    logic                      i_riscv_em_rst;
    logic                      i_issue_valid;
    riscv_em_pkg::em_issue_t   i_issue;
    logic                      o_issue_ready;
    logic                      o_retire_valid;
    riscv_em_pkg::em_retire_t  o_retire;
    logic                      i_retire_ready;

    riscv_em_pkg::em_retire_t  exp_q[$];
    logic [`RISCV_EM_XLEN-1:0] shadow [0:`RISCV_EM_DMEM_WORDS-1];
    int                        errors    = 0;
    int                        retired   = 0;
    bit                        timed_out = 1'b0;
    logic                      em_busy   = 1'b0;   // what the EM slot should hold.
    logic                      em_trap   = 1'b0;
    logic                      ret_busy  = 1'b0;   // retire slot as the model sees it.
    logic                      ret_trap  = 1'b0;
    logic                      trap_wait = 1'b0;

    riscv_em_top dut0 (
        .i_riscv_em_clk (i_riscv_em_clk),
        .i_riscv_em_rst (i_riscv_em_rst),
        .i_issue_valid  (i_issue_valid),
        .i_issue        (i_issue),
        .o_issue_ready  (o_issue_ready),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire),
        .i_retire_ready (i_retire_ready)
    );

    initial
    begin
        i_riscv_em_clk = 1'b0;
        forever #20 i_riscv_em_clk = ~i_riscv_em_clk;
    end

    task automatic check_value(string name, logic [63:0] got, logic [63:0] want);
        if (got !== want)
        begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    function automatic riscv_em_pkg::em_retire_t predict_retire(riscv_em_pkg::em_issue_t item);
        riscv_em_pkg::em_retire_t r;
        logic [63:0] addr;
        logic [63:0] mask;
        logic [63:0] word;
        int nbytes;
        int ofs;
        int idx;
        addr   = item.rs1 + item.imm;
        nbytes = 1 << item.size;
        ofs    = int'(addr[2:0]);
        idx    = int'((addr >> 3) % `RISCV_EM_DMEM_WORDS);
        mask   = (nbytes == 8) ? '1 : (64'd1 << (8 * nbytes)) - 64'd1;
        r.tag  = item.tag;
        r.rd   = item.rd;
        r.regw = item.regw;
        r.data = addr;
        r.trap = riscv_em_pkg::TRAP_NONE;
        case (item.op)
            riscv_em_pkg::OP_ADD: r.data = item.rs1 + item.rs2;
            riscv_em_pkg::OP_SUB: r.data = item.rs1 - item.rs2;
            riscv_em_pkg::OP_AND: r.data = item.rs1 & item.rs2;
            riscv_em_pkg::OP_OR:  r.data = item.rs1 | item.rs2;
            riscv_em_pkg::OP_XOR: r.data = item.rs1 ^ item.rs2;
            riscv_em_pkg::OP_SLL: r.data = item.rs1 << item.rs2[5:0];
            riscv_em_pkg::OP_LOAD:
                r.trap = (addr % nbytes != 0) ? riscv_em_pkg::TRAP_LD_MISALIGN : r.trap;
            riscv_em_pkg::OP_STORE:
                r.trap = (addr % nbytes != 0) ? riscv_em_pkg::TRAP_ST_MISALIGN : r.trap;
            default: r.trap = riscv_em_pkg::TRAP_ILLEGAL;
        endcase
        if (r.trap != riscv_em_pkg::TRAP_NONE || item.op == riscv_em_pkg::OP_STORE)
            r.regw = 1'b0;
        if (r.trap == riscv_em_pkg::TRAP_NONE && item.op == riscv_em_pkg::OP_LOAD)
        begin
            word = (shadow[idx] >> (8 * ofs)) & mask;
            if (!item.is_unsigned && word[8 * nbytes - 1])
                word = word | ~mask;   // sign fill.
            r.data = word;
        end
        if (r.trap == riscv_em_pkg::TRAP_NONE && item.op == riscv_em_pkg::OP_STORE)
            shadow[idx] = (shadow[idx] & ~(mask << (8 * ofs))) |
                          ((item.rs2 & mask) << (8 * ofs));
        return r;
    endfunction

    function automatic riscv_em_pkg::em_issue_t random_issue(logic [7:0] tag);
        riscv_em_pkg::em_issue_t item;
        int kind;
        int sz;
        kind             = $urandom % 16;
        sz               = $urandom % 4;
        item.tag         = tag;
        item.size        = riscv_em_pkg::em_size_e'(sz);
        item.is_unsigned = 1'($urandom);
        item.rs1         = {$urandom, $urandom};
        item.rs2         = {$urandom, $urandom};
        item.imm         = '0;
        item.rd          = 5'($urandom);
        item.regw        = 1'b1;
        if (kind < 6)
            item.op = riscv_em_pkg::em_op_e'(kind);
        else if (kind == 15)
            item.op = riscv_em_pkg::em_op_e'(4'(8 + $urandom % 8));   // illegal.
        else
        begin
            item.op  = (kind < 10) ? riscv_em_pkg::OP_LOAD : riscv_em_pkg::OP_STORE;
            // 16 hot words, high bits exercise the wrap.
            item.rs1 = {$urandom, 23'd0, 9'($urandom % 16) << 3};
            item.imm = 64'(($urandom % 5 == 0) ? $urandom % 8 : (($urandom % 8) >> sz) << sz);
        end
        return item;
    endfunction

    task automatic send(riscv_em_pkg::em_issue_t item);
        int waited;
        waited = 0;
        i_issue_valid <= 1'b1;
        i_issue       <= item;
        @(posedge i_riscv_em_clk);
        while (!o_issue_ready && waited < 100)
        begin
            @(posedge i_riscv_em_clk);
            waited++;
        end
        if (!o_issue_ready)
        begin
            errors++;
            timed_out = 1'b1;
            $display("issue of tag %0d was not accepted within 100 cycles", item.tag);
        end
        i_issue_valid <= 1'b0;
    endtask

    always @(posedge i_riscv_em_clk)
        i_retire_ready <= ($urandom % 4) != 0;   // stall about a quarter of cycles.

    // follows the EM slot to know when a trap leaves it.
    always @(posedge i_riscv_em_clk)
    begin : track_issue
        logic adv;
        logic flush;
        logic acc;
        riscv_em_pkg::em_retire_t want;
        if (!i_riscv_em_rst)
        begin
            adv   = !ret_busy || i_retire_ready;
            flush = adv && em_busy && em_trap;
            check_value("o_retire_valid", o_retire_valid, ret_busy);
            check_value("o_issue_ready", o_issue_ready, adv && !trap_wait);
            acc   = i_issue_valid && o_issue_ready;
            if (ret_busy && i_retire_ready && ret_trap)
                trap_wait = 1'b0;
            if (adv)
            begin
                ret_busy = em_busy;
                ret_trap = em_busy && em_trap;
            end
            if (flush)
            begin
                trap_wait = 1'b1;
                em_busy   = 1'b0;   // same-edge issue is dropped.
            end
            else if (adv)
            begin
                em_busy = acc;
                if (acc)
                begin
                    want = predict_retire(i_issue);
                    exp_q.push_back(want);
                    em_trap = want.trap != riscv_em_pkg::TRAP_NONE;
                end
            end
        end
    end

    always @(posedge i_riscv_em_clk)
    begin : compare_retire
        riscv_em_pkg::em_retire_t want;
        if (!i_riscv_em_rst && o_retire_valid && i_retire_ready)
        begin
            retired++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("retire of tag %0d at %0t with nothing expected", o_retire.tag, $time);
            end
            else
            begin
                want = exp_q.pop_front();
                check_value("o_retire.tag", o_retire.tag, want.tag);
                check_value("o_retire.rd", o_retire.rd, want.rd);
                check_value("o_retire.regw", o_retire.regw, want.regw);
                check_value("o_retire.trap", o_retire.trap, want.trap);
                if (want.trap == riscv_em_pkg::TRAP_NONE)
                    check_value("o_retire.data", o_retire.data, want.data);
            end
        end
    end

    initial
    begin
        riscv_em_pkg::em_issue_t item;
        logic [63:0] addr;
        int waited;
        void'($urandom(32'ha2a6));
        i_riscv_em_rst = 1'b1;
        i_issue_valid  = 1'b0;
        i_issue        = '0;
        i_retire_ready = 1'b0;
        repeat (4) @(posedge i_riscv_em_clk);
        i_riscv_em_rst <= 1'b0;
        // fill every word first.
        for (int i = 0; i < `RISCV_EM_DMEM_WORDS && !timed_out; i++)
        begin
            addr      = 64'(i) << 3;
            item      = '0;
            item.tag  = 8'(i);
            item.op   = riscv_em_pkg::OP_STORE;
            item.size = riscv_em_pkg::SZ_DBL;
            item.rs1  = addr;
            item.rs2  = {addr[31:0], ~addr[31:0]} ^ 64'h5a5a_0f0f_3c3c_9696;
            send(item);
        end
        for (int n = 0; n < 400 && !timed_out; n++)
        begin
            send(random_issue(8'(n)));
            repeat ($urandom % 3) @(posedge i_riscv_em_clk);
        end
        waited = 0;
        while (exp_q.size() != 0 && waited < 200)
        begin
            @(negedge i_riscv_em_clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d expected records never retired", exp_q.size());
        end
        repeat (2) @(negedge i_riscv_em_clk);
        $display("%0d retired, %0d check errors, %0d assertion failures",
                 retired, errors, dut0.u_sva.fails);
        if (errors == 0 && dut0.u_sva.fails == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- rtl/riscv_em_cfg.svh
`ifndef RISCV_EM_CFG_SVH
`define RISCV_EM_CFG_SVH

// data and address width.
`define RISCV_EM_XLEN 64

// 64-bit words in the data memory.
`define RISCV_EM_DMEM_WORDS 64

// tag carried with each operation.
`define RISCV_EM_TAG_W 8

`endif

//--- rtl/riscv_em_ctrl.sv
`timescale 1ns/1ns

module riscv_em_ctrl (
    input  logic i_riscv_em_clk,
    input  logic i_riscv_em_rst,
    input  logic i_retire_valid,
    input  logic i_retire_ready,
    input  logic i_trap_m,
    input  logic i_retire_trap,
    output logic o_issue_ready,
    output logic o_em_hold,
    output logic o_em_flush,
    output logic o_advance
);

    riscv_em_pkg::em_state_e state;
    riscv_em_pkg::em_state_e state_nxt;

    logic retire_fire;

    assign retire_fire = i_retire_valid & i_retire_ready;

    // retire slot is free or emptying this edge.
    assign o_advance  = !i_retire_valid | i_retire_ready;
    assign o_em_hold  = !o_advance;
    assign o_em_flush = o_advance & i_trap_m;   // kills whatever issues alongside.

    assign o_issue_ready = (state == riscv_em_pkg::ST_RUN) & o_advance;

    always_comb
    begin
        state_nxt = state;
        case (state)
            riscv_em_pkg::ST_RUN:
            begin
                if (o_em_flush)
                    state_nxt = riscv_em_pkg::ST_DRAIN;
            end
            default:
            begin
                // wait for the trap itself to leave.
                if (retire_fire && i_retire_trap)
                    state_nxt = riscv_em_pkg::ST_RUN;
            end
        endcase
    end

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
            state <= riscv_em_pkg::ST_RUN;
        else
            state <= state_nxt;
    end

endmodule

//--- rtl/riscv_em_pkg.sv
`include "riscv_em_cfg.svh"

package riscv_em_pkg;

    // operations; encodings 8 to 15 are illegal.
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_LOAD  = 4'd6,
        OP_STORE = 4'd7
    } em_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2,
        SZ_DBL  = 2'd3
    } em_size_e;

    typedef enum logic [1:0] {
        TRAP_NONE        = 2'd0,
        TRAP_ILLEGAL     = 2'd1,
        TRAP_LD_MISALIGN = 2'd2,
        TRAP_ST_MISALIGN = 2'd3
    } em_trap_e;

    typedef enum logic {
        ST_RUN   = 1'b0,
        ST_DRAIN = 1'b1
    } em_state_e;

    typedef struct packed {
        logic [`RISCV_EM_TAG_W-1:0] tag;
        em_op_e                     op;
        em_size_e                   size;
        logic                       is_unsigned;
        logic [`RISCV_EM_XLEN-1:0]  rs1;
        logic [`RISCV_EM_XLEN-1:0]  rs2;
        logic [`RISCV_EM_XLEN-1:0]  imm;
        logic [4:0]                 rd;
        logic                       regw;
    } em_issue_t;

    typedef struct packed {
        logic                       valid;
        logic [`RISCV_EM_TAG_W-1:0] tag;
        em_op_e                     op;
        em_size_e                   size;
        logic                       is_unsigned;
        logic [`RISCV_EM_XLEN-1:0]  result;      // alu value or address.
        logic [`RISCV_EM_XLEN-1:0]  storedata;
        logic [4:0]                 rd;
        logic                       regw;
        em_trap_e                   trap;
    } em_exmem_t;

    typedef struct packed {
        logic [`RISCV_EM_TAG_W-1:0] tag;
        logic [4:0]                 rd;
        logic                       regw;
        logic [`RISCV_EM_XLEN-1:0]  data;
        em_trap_e                   trap;
    } em_retire_t;

endpackage

//--- rtl/riscv_em_top.sv
`timescale 1ns/1ns

module riscv_em_top (
    input  logic                     i_riscv_em_clk,
    input  logic                     i_riscv_em_rst,
    input  logic                     i_issue_valid,
    input  riscv_em_pkg::em_issue_t  i_issue,
    output logic                     o_issue_ready,
    output logic                     o_retire_valid,
    output riscv_em_pkg::em_retire_t o_retire,
    input  logic                     i_retire_ready
);

    riscv_em_pkg::em_exmem_t em_d;
    riscv_em_pkg::em_exmem_t em_q;

    logic em_hold;
    logic em_flush;
    logic advance;
    logic trap_m;
    logic retire_trap;

    assign retire_trap = o_retire.trap != riscv_em_pkg::TRAP_NONE;

    riscv_ex_unit u_ex (
        .i_issue_valid (i_issue_valid),
        .i_issue       (i_issue),
        .i_issue_ready (o_issue_ready),
        .o_exmem       (em_d)
    );

    riscv_ppreg_em u_em (
        .i_riscv_em_clk   (i_riscv_em_clk),
        .i_riscv_em_rst   (i_riscv_em_rst),
        .i_riscv_em_en    (em_hold),
        .i_riscv_em_flush (em_flush),
        .i_riscv_em_d     (em_d),
        .o_riscv_em_q     (em_q)
    );

    riscv_mem_stage u_mem (
        .i_riscv_em_clk (i_riscv_em_clk),
        .i_riscv_em_rst (i_riscv_em_rst),
        .i_exmem        (em_q),
        .i_advance      (advance),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire),
        .o_trap_m       (trap_m)
    );

    riscv_em_ctrl u_ctrl (
        .i_riscv_em_clk (i_riscv_em_clk),
        .i_riscv_em_rst (i_riscv_em_rst),
        .i_retire_valid (o_retire_valid),
        .i_retire_ready (i_retire_ready),
        .i_trap_m       (trap_m),
        .i_retire_trap  (retire_trap),
        .o_issue_ready  (o_issue_ready),
        .o_em_hold      (em_hold),
        .o_em_flush     (em_flush),
        .o_advance      (advance)
    );

endmodule

//--- rtl/riscv_ex_unit.sv
`timescale 1ns/1ns
`include "riscv_em_cfg.svh"

module riscv_ex_unit (
    input  logic                    i_issue_valid,
    input  riscv_em_pkg::em_issue_t i_issue,
    input  logic                    i_issue_ready,
    output riscv_em_pkg::em_exmem_t o_exmem
);

    localparam int SHAMT_W = $clog2(`RISCV_EM_XLEN);

    logic [`RISCV_EM_XLEN-1:0] addr;
    logic [`RISCV_EM_XLEN-1:0] alu;
    logic                      legal;
    logic                      misalign;

    assign addr = i_issue.rs1 + i_issue.imm;

    always_comb
    begin
        legal = 1'b1;
        alu   = '0;
        case (i_issue.op)
            riscv_em_pkg::OP_ADD:   alu = i_issue.rs1 + i_issue.rs2;
            riscv_em_pkg::OP_SUB:   alu = i_issue.rs1 - i_issue.rs2;
            riscv_em_pkg::OP_AND:   alu = i_issue.rs1 & i_issue.rs2;
            riscv_em_pkg::OP_OR:    alu = i_issue.rs1 | i_issue.rs2;
            riscv_em_pkg::OP_XOR:   alu = i_issue.rs1 ^ i_issue.rs2;
            riscv_em_pkg::OP_SLL:   alu = i_issue.rs1 << i_issue.rs2[SHAMT_W-1:0];
            riscv_em_pkg::OP_LOAD,
            riscv_em_pkg::OP_STORE: alu = addr;
            default:                legal = 1'b0;
        endcase
    end

    // natural alignment per access size.
    always_comb
    begin
        case (i_issue.size)
            riscv_em_pkg::SZ_BYTE: misalign = 1'b0;
            riscv_em_pkg::SZ_HALF: misalign = addr[0];
            riscv_em_pkg::SZ_WORD: misalign = |addr[1:0];
            default:               misalign = |addr[2:0];
        endcase
    end

    always_comb
    begin
        o_exmem.valid       = i_issue_valid & i_issue_ready;   // issue handshake.
        o_exmem.tag         = i_issue.tag;
        o_exmem.op          = i_issue.op;
        o_exmem.size        = i_issue.size;
        o_exmem.is_unsigned = i_issue.is_unsigned;
        o_exmem.result      = alu;
        o_exmem.storedata   = i_issue.rs2;
        o_exmem.rd          = i_issue.rd;
        o_exmem.regw        = i_issue.regw;
        if (!legal)
            o_exmem.trap = riscv_em_pkg::TRAP_ILLEGAL;
        else if (misalign && i_issue.op == riscv_em_pkg::OP_LOAD)
            o_exmem.trap = riscv_em_pkg::TRAP_LD_MISALIGN;
        else if (misalign && i_issue.op == riscv_em_pkg::OP_STORE)
            o_exmem.trap = riscv_em_pkg::TRAP_ST_MISALIGN;
        else
            o_exmem.trap = riscv_em_pkg::TRAP_NONE;
    end

endmodule

//--- rtl/riscv_mem_stage.sv
`timescale 1ns/1ns
`include "riscv_em_cfg.svh"

module riscv_mem_stage (
    input  logic                     i_riscv_em_clk,
    input  logic                     i_riscv_em_rst,
    input  riscv_em_pkg::em_exmem_t  i_exmem,
    input  logic                     i_advance,
    output logic                     o_retire_valid,
    output riscv_em_pkg::em_retire_t o_retire,
    output logic                     o_trap_m
);

    localparam int BYTES = `RISCV_EM_XLEN / 8;
    localparam int OFS_W = $clog2(BYTES);
    localparam int IDX_W = $clog2(`RISCV_EM_DMEM_WORDS);

    logic [`RISCV_EM_XLEN-1:0] dmem [0:`RISCV_EM_DMEM_WORDS-1];
    logic [IDX_W-1:0]          idx;
    logic [OFS_W-1:0]          ofs;
    logic [`RISCV_EM_XLEN-1:0] rd_shift;
    logic [`RISCV_EM_XLEN-1:0] ld_data;
    logic [`RISCV_EM_XLEN-1:0] st_data;
    logic [BYTES-1:0]          st_mask;
    logic [BYTES-1:0]          st_be;
    logic                      trap;
    logic                      is_load;
    logic                      is_store;
    logic                      sx;

    assign idx      = i_exmem.result[OFS_W +: IDX_W];   // wraps modulo depth.
    assign ofs      = i_exmem.result[OFS_W-1:0];
    assign trap     = i_exmem.trap != riscv_em_pkg::TRAP_NONE;
    assign o_trap_m = i_exmem.valid & trap;
    assign is_load  = (i_exmem.op == riscv_em_pkg::OP_LOAD) & !trap;
    assign is_store = i_exmem.valid & !trap & (i_exmem.op == riscv_em_pkg::OP_STORE);
    assign sx       = !i_exmem.is_unsigned;

    assign rd_shift = dmem[idx] >> {ofs, 3'b000};
    assign st_data  = i_exmem.storedata << {ofs, 3'b000};
    assign st_be    = st_mask << ofs;

    always_comb
    begin
        case (i_exmem.size)
            riscv_em_pkg::SZ_BYTE:
            begin
                st_mask = 8'h01;
                ld_data = {{(`RISCV_EM_XLEN-8){sx & rd_shift[7]}}, rd_shift[7:0]};
            end
            riscv_em_pkg::SZ_HALF:
            begin
                st_mask = 8'h03;
                ld_data = {{(`RISCV_EM_XLEN-16){sx & rd_shift[15]}}, rd_shift[15:0]};
            end
            riscv_em_pkg::SZ_WORD:
            begin
                st_mask = 8'h0f;
                ld_data = {{(`RISCV_EM_XLEN-32){sx & rd_shift[31]}}, rd_shift[31:0]};
            end
            default:
            begin
                st_mask = 8'hff;
                ld_data = rd_shift;
            end
        endcase
    end

    // store commits only as it moves into retire.
    always_ff @(posedge i_riscv_em_clk)
    begin
        if (i_advance && is_store)
        begin
            for (int b = 0; b < BYTES; b++)
            begin
                if (st_be[b])
                    dmem[idx][8*b +: 8] <= st_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
            o_retire_valid <= 1'b0;
        else if (i_advance)
            o_retire_valid <= i_exmem.valid;
    end

    always_ff @(posedge i_riscv_em_clk)
    begin
        if (i_advance)
        begin
            o_retire.tag  <= i_exmem.tag;
            o_retire.rd   <= i_exmem.rd;
            o_retire.regw <= i_exmem.regw & !trap &
                             (i_exmem.op != riscv_em_pkg::OP_STORE);
            o_retire.data <= is_load ? ld_data : i_exmem.result;
            o_retire.trap <= i_exmem.trap;
        end
    end

endmodule

//--- rtl/riscv_ppreg_em.sv
`timescale 1ns/1ns

module riscv_ppreg_em (
    input  logic                    i_riscv_em_clk,
    input  logic                    i_riscv_em_rst,
    input  logic                    i_riscv_em_en,     // high holds the entry.
    input  logic                    i_riscv_em_flush,
    input  riscv_em_pkg::em_exmem_t i_riscv_em_d,
    output riscv_em_pkg::em_exmem_t o_riscv_em_q
);

    // flush wins over hold so a stalled entry can still be killed.
    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            o_riscv_em_q <= '0;
        end
        else if (i_riscv_em_flush)
        begin
            o_riscv_em_q <= '0;
        end
        else if (!i_riscv_em_en)
        begin
            o_riscv_em_q <= i_riscv_em_d;
        end
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/riscv_em_pkg.sv
rtl/riscv_ex_unit.sv
rtl/riscv_ppreg_em.sv
rtl/riscv_mem_stage.sv
rtl/riscv_em_ctrl.sv
rtl/riscv_em_top.sv
bench/riscv_em_assertions.sv
bench/riscv_em_tb.sv
